//--- src/matrix_pkg.sv
package matrix_pkg;

    // Panel geometry
    localparam int PANEL_COLUMNS   = 64;
    localparam int PANEL_ROW_PAIRS = 16; // Row r and r+16 lit together
    localparam int BIT_PLANES      = 6;

    // Serial line, clk_root cycles per bit
    localparam int UART_TICKS_PER_BIT = 65;

    // Scan timing in clk_root cycles
    localparam int PIXEL_PERIOD = 8;
    localparam int OE_UNIT      = 16; // Plane p lit for OE_UNIT << p

    typedef logic [15:0] pixel_t;      // RGB565, red on top
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] byte_addr_t;  // Even byte is the high half
    typedef logic [10:0] pixel_addr_t; // row * 64 + column
    typedef logic [5:0]  column_t;
    typedef logic [3:0]  row_t;
    typedef logic [2:0]  rgb_t;        // Red bit 0, green bit 1, blue bit 2
    typedef logic [5:0]  plane_mask_t;

endpackage

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic              clk_root,
    input  logic              reset,
    input  logic              uart_rx,
    output matrix_pkg::byte_t rx_data,
    output logic              rx_valid,
    output logic              rx_running
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_TAIL
    } rx_state_e;

    rx_state_e         state;
    logic [1:0]        line_sync;
    logic              line_prev;
    logic [6:0]        tick_count;
    logic [2:0]        bit_count;
    matrix_pkg::byte_t shift_reg;
    logic              tick_half;
    logic              tick_full;
    logic              tick_tail;

    assign tick_half = tick_count == 7'(matrix_pkg::UART_TICKS_PER_BIT / 2 - 1);
    assign tick_full = tick_count == 7'(matrix_pkg::UART_TICKS_PER_BIT - 1);
    // Tail ends a little early so a back-to-back start bit is seen
    assign tick_tail = tick_count == 7'(matrix_pkg::UART_TICKS_PER_BIT / 2 - 4);

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk_root) begin
        if (reset) begin
            line_sync <= 2'b11;
            line_prev <= 1'b1;
        end else begin
            line_sync <= {line_sync[0], uart_rx};
            line_prev <= line_sync[1];
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state      <= RX_IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid   <= 1'b0;
            tick_count <= tick_count + 7'd1;
            case (state)
                RX_IDLE: begin
                    tick_count <= '0;
                    if (line_prev && !line_sync[1]) begin
                        state <= RX_START; // Falling edge
                    end
                end
                RX_START: begin
                    if (tick_half) begin
                        tick_count <= '0;
                        bit_count  <= '0;
                        state      <= line_sync[1] ? RX_IDLE : RX_DATA; // Glitch check
                    end
                end
                RX_DATA: begin
                    if (tick_full) begin
                        tick_count <= '0;
                        bit_count  <= bit_count + 3'd1;
                        if (bit_count == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick_full) begin
                        tick_count <= '0;
                        rx_valid   <= line_sync[1]; // Low stop bit drops the byte
                        state      <= RX_TAIL;
                    end
                end
                RX_TAIL: begin
                    if (tick_tail) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && tick_full) begin
            shift_reg <= {line_sync[1], shift_reg[7:1]};
        end
        if (state == RX_STOP && tick_full && line_sync[1]) begin
            rx_data <= shift_reg;
        end
    end

    assign rx_running = state != RX_IDLE;

endmodule

//--- src/control_module.sv
`timescale 1ns/1ps

module control_module (
    input  logic                    clk_root,
    input  logic                    reset,
    input  matrix_pkg::byte_t       rx_data,
    input  logic                    rx_valid,
    output matrix_pkg::byte_addr_t  ram_address,
    output matrix_pkg::byte_t       ram_data,
    output logic                    ram_write_enable,
    output matrix_pkg::rgb_t        rgb_enable,
    output matrix_pkg::plane_mask_t brightness_enable
);

    typedef enum logic [2:0] {
        PARSE_IDLE,
        PARSE_CHANNEL,
        PARSE_PLANE,
        PARSE_ROW,
        PARSE_PIXELS
    } parse_state_e;

    parse_state_e state;
    logic [4:0]   row_select;  // Panel row 0..31
    logic [6:0]   byte_count;  // Byte within the row, 2 per column

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state             <= PARSE_IDLE;
            byte_count        <= '0;
            ram_write_enable  <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            ram_write_enable <= 1'b0;
            if (rx_valid) begin
                case (state)
                    PARSE_IDLE: begin
                        if (rx_data == "C") begin
                            state <= PARSE_CHANNEL;
                        end else if (rx_data == "B") begin
                            state <= PARSE_PLANE;
                        end else if (rx_data == "L") begin
                            state <= PARSE_ROW;
                        end
                        // Anything else is dropped
                    end
                    PARSE_CHANNEL: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= PARSE_IDLE;
                    end
                    PARSE_PLANE: begin
                        brightness_enable <= rx_data[5:0];
                        state             <= PARSE_IDLE;
                    end
                    PARSE_ROW: begin
                        byte_count <= '0;
                        state      <= PARSE_PIXELS;
                    end
                    PARSE_PIXELS: begin
                        ram_write_enable <= 1'b1;
                        byte_count       <= byte_count + 7'd1;
                        if (byte_count == 7'd127) begin
                            state <= PARSE_IDLE; // Row complete
                        end
                    end
                    default: state <= PARSE_IDLE;
                endcase
            end
        end
    end

    // Write payload, qualified by ram_write_enable
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == PARSE_ROW) begin
            row_select <= rx_data[4:0];
        end
        if (rx_valid && state == PARSE_PIXELS) begin
            ram_address <= {row_select, byte_count}; // row * 128 + byte
            ram_data    <= rx_data;
        end
    end

endmodule

//--- src/framebuffer_ram.sv
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                    clk_root,
    input  matrix_pkg::byte_addr_t  write_address,
    input  matrix_pkg::byte_t       write_data,
    input  logic                    write_enable,
    input  matrix_pkg::pixel_addr_t read_address,
    output matrix_pkg::pixel_t      read_data
);

    // One byte bank per half of the RGB565 word
    matrix_pkg::byte_t bank_high [2**$bits(matrix_pkg::pixel_addr_t)];
    matrix_pkg::byte_t bank_low  [2**$bits(matrix_pkg::pixel_addr_t)];

    always_ff @(posedge clk_root) begin
        if (write_enable) begin
            if (write_address[0]) begin
                bank_low[write_address[11:1]] <= write_data;
            end else begin
                bank_high[write_address[11:1]] <= write_data; // Even byte
            end
        end
    end

    // One cycle read latency
    always_ff @(posedge clk_root) begin
        read_data <= {bank_high[read_address], bank_low[read_address]};
    end

endmodule

//--- src/framebuffer_fetch.sv
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                    clk_root,
    input  logic                    reset,
    input  logic                    pixel_load_start,
    input  matrix_pkg::column_t     column_address,
    input  matrix_pkg::row_t        row_address,
    output matrix_pkg::pixel_addr_t ram_address,
    input  matrix_pkg::pixel_t      ram_data,
    output matrix_pkg::pixel_t      rgb565_top,
    output matrix_pkg::pixel_t      rgb565_bottom
);

    // Step 1 reads top, step 2 catches top, step 3 presents both
    logic [1:0]         step;
    matrix_pkg::pixel_t top_hold;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            step <= '0;
        end else if (pixel_load_start) begin
            step <= 2'd1;
        end else if (step != 2'd0) begin
            step <= step + 2'd1; // Back to idle after 3
        end
    end

    always_ff @(posedge clk_root) begin
        if (pixel_load_start) begin
            ram_address <= {1'b0, row_address, column_address};
        end else if (step == 2'd1) begin
            ram_address <= {1'b1, ram_address[9:0]}; // Row + 16
        end

        if (step == 2'd2) begin
            top_hold <= ram_data;
        end

        // Both halves change on the same edge
        if (step == 2'd3) begin
            rgb565_top    <= top_hold;
            rgb565_bottom <= ram_data;
        end
    end

endmodule

//--- src/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan (
    input  logic                    clk_root,
    input  logic                    reset,
    output matrix_pkg::column_t     column_address,
    output matrix_pkg::row_t        row_address,
    output logic                    pixel_load_start,
    output logic                    clk_pixel,
    output logic                    row_latch,
    output logic                    output_enable,
    output matrix_pkg::row_t        row_address_active,
    output matrix_pkg::plane_mask_t plane_mask
);

    typedef enum logic [1:0] {
        SCAN_SHIFT,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_e;

    scan_state_e state;
    logic [2:0]  phase;       // Cycle within a column
    logic [2:0]  plane;
    logic [9:0]  wait_count;  // Latch and display timer
    logic [9:0]  display_last;
    logic        last_phase;
    logic        last_column;
    logic        last_plane;

    assign last_phase   = phase == 3'(matrix_pkg::PIXEL_PERIOD - 1);
    assign last_column  = column_address == matrix_pkg::column_t'(matrix_pkg::PANEL_COLUMNS - 1);
    assign last_plane   = plane == 3'(matrix_pkg::BIT_PLANES - 1);
    assign display_last = 10'((matrix_pkg::OE_UNIT << plane) - 1); // Binary weighted

    assign plane_mask = matrix_pkg::plane_mask_t'(1) << plane;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state          <= SCAN_SHIFT;
            phase          <= '0;
            column_address <= '0;
            plane          <= '0;
            row_address    <= '0;
            wait_count     <= '0;
        end else begin
            case (state)
                SCAN_SHIFT: begin
                    phase <= phase + 3'd1;
                    if (last_phase) begin
                        phase          <= '0;
                        column_address <= column_address + 6'd1; // Wraps after 63
                        if (last_column) begin
                            wait_count <= '0;
                            state      <= SCAN_LATCH;
                        end
                    end
                end
                SCAN_LATCH: begin
                    wait_count <= wait_count + 10'd1;
                    if (wait_count == 10'd1) begin
                        wait_count <= '0;
                        state      <= SCAN_DISPLAY;
                    end
                end
                SCAN_DISPLAY: begin
                    wait_count <= wait_count + 10'd1;
                    if (wait_count == display_last) begin
                        state <= SCAN_SHIFT;
                        if (last_plane) begin
                            plane <= '0;
                            if (row_address == matrix_pkg::row_t'(matrix_pkg::PANEL_ROW_PAIRS - 1))
                            begin
                                row_address <= '0;
                            end else begin
                                row_address <= row_address + 4'd1;
                            end
                        end else begin
                            plane <= plane + 3'd1;
                        end
                    end
                end
                default: state <= SCAN_SHIFT;
            endcase
        end
    end

    // Panel strobes trail the counters by one cycle
    always_ff @(posedge clk_root) begin
        if (reset) begin
            pixel_load_start   <= 1'b0;
            clk_pixel          <= 1'b0;
            row_latch          <= 1'b0;
            output_enable      <= 1'b0;
            row_address_active <= '0;
        end else begin
            pixel_load_start <= state == SCAN_SHIFT && phase == 3'd0;
            clk_pixel        <= state == SCAN_SHIFT && phase >= 3'(matrix_pkg::PIXEL_PERIOD - 2);
            row_latch        <= state == SCAN_LATCH;
            output_enable    <= state == SCAN_DISPLAY;
            if (state == SCAN_LATCH) begin
                row_address_active <= row_address; // Settled before OE rises
            end
        end
    end

endmodule

//--- src/pixel_split.sv
`timescale 1ns/1ps

module pixel_split (
    input  matrix_pkg::pixel_t      pixel,
    input  matrix_pkg::plane_mask_t plane_mask,
    input  matrix_pkg::plane_mask_t brightness_enable,
    input  matrix_pkg::rgb_t        rgb_enable,
    output matrix_pkg::rgb_t        rgb
);

    matrix_pkg::plane_mask_t red6;
    matrix_pkg::plane_mask_t green6;
    matrix_pkg::plane_mask_t blue6;
    matrix_pkg::plane_mask_t active;

    // 5-bit channels get their MSB repeated as the new LSB
    assign red6   = {pixel[15:11], pixel[15]};
    assign green6 = pixel[10:5];
    assign blue6  = {pixel[4:0], pixel[4]};

    assign active = plane_mask & brightness_enable; // Empty when plane is disabled

    assign rgb[0] = rgb_enable[0] & |(red6 & active);
    assign rgb[1] = rgb_enable[1] & |(green6 & active);
    assign rgb[2] = rgb_enable[2] & |(blue6 & active);

endmodule

//--- src/led_matrix_top.sv
`timescale 1ns/1ps

module led_matrix_top (
    input  logic             clk_root,
    input  logic             reset,
    input  logic             uart_rx,
    output logic             rx_running,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output matrix_pkg::row_t row_address_active,
    output matrix_pkg::rgb_t rgb1,
    output matrix_pkg::rgb_t rgb2
);

    matrix_pkg::byte_t       rx_data;
    logic                    rx_valid;
    matrix_pkg::byte_addr_t  ram_a_address;
    matrix_pkg::byte_t       ram_a_data;
    logic                    ram_a_write_enable;
    matrix_pkg::pixel_addr_t ram_b_address;
    matrix_pkg::pixel_t      ram_b_data;
    matrix_pkg::rgb_t        rgb_enable;
    matrix_pkg::plane_mask_t brightness_enable;
    matrix_pkg::column_t     column_address;
    matrix_pkg::row_t        row_address;
    logic                    pixel_load_start;
    matrix_pkg::plane_mask_t plane_mask;
    matrix_pkg::pixel_t      pixel_rgb565_top;
    matrix_pkg::pixel_t      pixel_rgb565_bottom;

    uart_rx u_uart_rx (
        .clk_root   (clk_root),
        .reset      (reset),
        .uart_rx    (uart_rx),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_running (rx_running)
    );

    control_module u_control (
        .clk_root          (clk_root),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .ram_address       (ram_a_address),
        .ram_data          (ram_a_data),
        .ram_write_enable  (ram_a_write_enable),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    // Byte writes from the parser, word reads for the scan
    framebuffer_ram u_framebuffer (
        .clk_root      (clk_root),
        .write_address (ram_a_address),
        .write_data    (ram_a_data),
        .write_enable  (ram_a_write_enable),
        .read_address  (ram_b_address),
        .read_data     (ram_b_data)
    );

    framebuffer_fetch u_fetch (
        .clk_root         (clk_root),
        .reset            (reset),
        .pixel_load_start (pixel_load_start),
        .column_address   (column_address),
        .row_address      (row_address),
        .ram_address      (ram_b_address),
        .ram_data         (ram_b_data),
        .rgb565_top       (pixel_rgb565_top),
        .rgb565_bottom    (pixel_rgb565_bottom)
    );

    matrix_scan u_scan (
        .clk_root           (clk_root),
        .reset              (reset),
        .column_address     (column_address),
        .row_address        (row_address),
        .pixel_load_start   (pixel_load_start),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .row_address_active (row_address_active),
        .plane_mask         (plane_mask)
    );

    // Upper half of the panel
    pixel_split u_split_top (
        .pixel             (pixel_rgb565_top),
        .plane_mask        (plane_mask),
        .brightness_enable (brightness_enable),
        .rgb_enable        (rgb_enable),
        .rgb               (rgb1)
    );

    // Lower half, rows 16..31
    pixel_split u_split_bottom (
        .pixel             (pixel_rgb565_bottom),
        .plane_mask        (plane_mask),
        .brightness_enable (brightness_enable),
        .rgb_enable        (rgb_enable),
        .rgb               (rgb2)
    );

endmodule

//--- verif/matrix_checker.sv
`timescale 1ns/1ps

module matrix_checker (
    input  logic                    clk_root,
    input  logic                    reset,
    input  logic                    clk_pixel,
    input  logic                    row_latch,
    input  logic                    output_enable,
    input  matrix_pkg::row_t        row_address_active,
    input  matrix_pkg::rgb_t        rgb1,
    input  matrix_pkg::rgb_t        rgb2,
    input  logic                    arm,
    input  logic [4:0]              target_row,
    input  matrix_pkg::pixel_t      expected_pixel,
    input  matrix_pkg::rgb_t        expected_rgb_enable,
    input  matrix_pkg::plane_mask_t expected_plane_enable,
    output int                      error_count,
    output int                      planes_checked
);

    matrix_pkg::rgb_t column_bits [matrix_pkg::PANEL_COLUMNS];
    logic reset_q;
    logic clk_pixel_q;
    logic row_latch_q;
    logic output_enable_q;
    logic clean;          // Whole shift since arm saw the new data
    int   edge_count;
    int   latch_count;
    int   latch_cycles;
    int   oe_cycles;
    int   shifted_plane;
    int   shifted_pair;

    // Six-bit level of a channel; 5-bit channels repeat their MSB below the LSB
    function automatic logic plane_bit(input matrix_pkg::pixel_t px, input int channel,
                                       input int plane);
        logic [5:0] level;
        case (channel)
            0:       level = (6'(px[15:11]) << 1) | 6'(px[15]);
            1:       level = px[10:5];
            default: level = (6'(px[4:0]) << 1) | 6'(px[4]);
        endcase
        return level[plane];
    endfunction

    task automatic compare_plane(input int plane);
        logic expected;
        logic got;
        for (int col = 0; col < matrix_pkg::PANEL_COLUMNS; col++) begin
            for (int ch = 0; ch < 3; ch++) begin
                expected = plane_bit(expected_pixel, ch, plane) &&
                           expected_plane_enable[plane] && expected_rgb_enable[ch];
                got = column_bits[col][ch];
                if (got !== expected) begin
                    $display("Fail %0t: channel %s plane %0d column %0d expected %b got %b",
                             $time, ch == 0 ? "red" : ch == 1 ? "green" : "blue",
                             plane, col, expected, got);
                    error_count++;
                end
            end
        end
    endtask

    always @(posedge clk_root) begin
        if (reset) begin
            edge_count     = 0;
            latch_count    = 0;
            latch_cycles   = 0;
            oe_cycles      = 0;
            clean          = 1'b0;
            error_count    = 0;
            planes_checked = 0;
        end else begin
            if (reset_q && (clk_pixel || row_latch || output_enable)) begin
                $display("Fail %0t: panel strobes not low after reset", $time);
                error_count++;
            end
            if (latch_count == 0 && (output_enable || row_address_active != '0)) begin
                $display("Fail %0t: display active before first latch, row %0d",
                         $time, row_address_active);
                error_count++;
            end
            if (output_enable && (row_latch || clk_pixel)) begin
                $display("Fail %0t: latch or pixel clock high during display", $time);
                error_count++;
            end

            if (clk_pixel && !clk_pixel_q) begin
                if (edge_count < matrix_pkg::PANEL_COLUMNS) begin
                    column_bits[edge_count] = target_row[4] ? rgb2 : rgb1; // Half by row
                end
                edge_count++;
            end

            if (row_latch && !row_latch_q) begin
                if (edge_count != matrix_pkg::PANEL_COLUMNS) begin
                    $display("Fail %0t: %0d pixel clocks before latch, expected %0d",
                             $time, edge_count, matrix_pkg::PANEL_COLUMNS);
                    error_count++;
                end
                // Scan order is plane 0..5 within each row pair from reset on
                shifted_plane = latch_count % matrix_pkg::BIT_PLANES;
                shifted_pair  = (latch_count / matrix_pkg::BIT_PLANES)
                                % matrix_pkg::PANEL_ROW_PAIRS;
                if (arm && clean && shifted_pair == int'(target_row[3:0])) begin
                    compare_plane(shifted_plane);
                    planes_checked++;
                end
                clean = arm;
                latch_count++;
                edge_count = 0;
            end

            if (row_latch) begin
                latch_cycles++;
            end else if (row_latch_q) begin
                if (latch_cycles != 2) begin
                    $display("Fail %0t: latch lasted %0d cycles, expected 2",
                             $time, latch_cycles);
                    error_count++;
                end
                latch_cycles = 0;
            end

            if (output_enable && !output_enable_q && latch_count > 0 &&
                int'(row_address_active) != ((latch_count - 1) / matrix_pkg::BIT_PLANES)
                % matrix_pkg::PANEL_ROW_PAIRS) begin
                $display("Fail %0t: row_address_active %0d, expected %0d", $time,
                         row_address_active,
                         ((latch_count - 1) / matrix_pkg::BIT_PLANES)
                         % matrix_pkg::PANEL_ROW_PAIRS);
                error_count++;
            end

            if (output_enable) begin
                oe_cycles++;
            end else if (output_enable_q) begin
                shifted_plane = (latch_count - 1) % matrix_pkg::BIT_PLANES;
                if (oe_cycles != (matrix_pkg::OE_UNIT << shifted_plane)) begin
                    $display("Fail %0t: plane %0d lit for %0d cycles, expected %0d", $time,
                             shifted_plane, oe_cycles, matrix_pkg::OE_UNIT << shifted_plane);
                    error_count++;
                end
                oe_cycles = 0;
            end

            if (!arm) begin
                planes_checked = 0;
            end
        end
        reset_q         = reset;
        clk_pixel_q     = clk_pixel;
        row_latch_q     = row_latch;
        output_enable_q = output_enable;
    end

endmodule

//--- verif/led_matrix_sva.sv
`timescale 1ns/1ps

module led_matrix_sva (
    input logic clk_root,
    input logic reset,
    input logic clk_pixel,
    input logic row_latch,
    input logic output_enable
);

    latch_outside_display: assert property (@(posedge clk_root) disable iff (reset)
        !(row_latch && output_enable))
        else $error("row_latch asserted while output_enable is high");

    // No shifting while a row is lit
    pixel_clock_dark: assert property (@(posedge clk_root) disable iff (reset)
        !(clk_pixel && output_enable))
        else $error("clk_pixel high during display");

    latch_two_cycles: assert property (@(posedge clk_root) disable iff (reset)
        $rose(row_latch) |=> row_latch ##1 !row_latch)
        else $error("row_latch pulse is not exactly two cycles long");

endmodule

bind matrix_scan led_matrix_sva i_scan_sva (
    .clk_root      (clk_root),
    .reset         (reset),
    .clk_pixel     (clk_pixel),
    .row_latch     (row_latch),
    .output_enable (output_enable)
);

//--- verif/tb_led_matrix.sv
`timescale 1ns/1ps

module tb_led_matrix;

    localparam int MAX_CASES     = 32;
    localparam int DRIVE_DELAY   = 2;
    localparam int IDLE_TIMEOUT  = 2000;
    localparam int CHECK_TIMEOUT = 200000; // About three frames

    logic                    clk_root = 1'b0;
    logic                    reset;
    logic                    uart_rx;
    logic                    rx_running;
    logic                    clk_pixel;
    logic                    row_latch;
    logic                    output_enable;
    matrix_pkg::row_t        row_address_active;
    matrix_pkg::rgb_t        rgb1;
    matrix_pkg::rgb_t        rgb2;
    logic                    arm;
    logic [4:0]              target_row;
    matrix_pkg::pixel_t      expected_pixel;
    matrix_pkg::rgb_t        expected_rgb_enable;
    matrix_pkg::plane_mask_t expected_plane_enable;
    int                      error_count;
    int                      planes_checked;
    int                      serial_errors;
    logic [15:0]             case_words [4 * MAX_CASES]; // Four words per case

    always #20 clk_root = ~clk_root;

    led_matrix_top i_led_matrix_top (
        .clk_root           (clk_root),
        .reset              (reset),
        .uart_rx            (uart_rx),
        .rx_running         (rx_running),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .row_address_active (row_address_active),
        .rgb1               (rgb1),
        .rgb2               (rgb2)
    );

    matrix_checker i_checker (
        .clk_root              (clk_root),
        .reset                 (reset),
        .clk_pixel             (clk_pixel),
        .row_latch             (row_latch),
        .output_enable         (output_enable),
        .row_address_active    (row_address_active),
        .rgb1                  (rgb1),
        .rgb2                  (rgb2),
        .arm                   (arm),
        .target_row            (target_row),
        .expected_pixel        (expected_pixel),
        .expected_rgb_enable   (expected_rgb_enable),
        .expected_plane_enable (expected_plane_enable),
        .error_count           (error_count),
        .planes_checked        (planes_checked)
    );

    // Sends an 8N1 frame LSB first from just after a clock edge
    task automatic send_byte(input matrix_pkg::byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (matrix_pkg::UART_TICKS_PER_BIT) @(posedge clk_root);
            #DRIVE_DELAY;
            // Receiver busy from the start bit until the stop bit
            if (i < 9 && !rx_running) begin
                $display("Fail %0t: rx_running low after bit %0d of byte %h",
                         $time, i, value);
                serial_errors++;
            end
        end
    endtask

    task automatic wait_receiver_idle(output bit ok);
        ok = 1'b0;
        for (int cycles = 0; cycles < IDLE_TIMEOUT && !ok; cycles++) begin
            @(posedge clk_root);
            #DRIVE_DELAY;
            ok = !rx_running;
        end
        if (!ok) begin
            $display("Timeout: serial receiver still busy after %0d cycles", IDLE_TIMEOUT);
        end
    endtask

    task automatic wait_planes_checked(output bit ok);
        ok = 1'b0;
        for (int cycles = 0; cycles < CHECK_TIMEOUT && !ok; cycles++) begin
            @(posedge clk_root);
            #DRIVE_DELAY;
            ok = planes_checked >= matrix_pkg::BIT_PLANES;
        end
        if (!ok) begin
            $display("Timeout: row %0d was not scanned through all planes", target_row);
        end
    endtask

    task automatic run_case(input int index, output bit ok);
        logic [4:0]              row;
        matrix_pkg::pixel_t      pixel;
        matrix_pkg::rgb_t        rgb_enable;
        matrix_pkg::plane_mask_t plane_enable;
        row          = case_words[4 * index][4:0];
        pixel        = case_words[4 * index + 1];
        rgb_enable   = case_words[4 * index + 2][2:0];
        plane_enable = case_words[4 * index + 3][5:0];
        send_byte("C");
        send_byte({5'b0, rgb_enable});
        send_byte("B");
        send_byte({2'b0, plane_enable});
        send_byte("L");
        send_byte({3'b0, row});
        for (int col = 0; col < matrix_pkg::PANEL_COLUMNS; col++) begin
            send_byte(pixel[15:8]); // High byte first
            send_byte(pixel[7:0]);
        end
        wait_receiver_idle(ok);
        if (ok) begin
            target_row            = row;
            expected_pixel        = pixel;
            expected_rgb_enable   = rgb_enable;
            expected_plane_enable = plane_enable;
            arm                   = 1'b1;
            wait_planes_checked(ok);
            arm = 1'b0;
        end
    endtask

    initial begin
        int case_count;
        int tests_run;
        int tests_failed;
        int errors_before;
        bit aborted;
        bit ok;
        uart_rx               = 1'b1;
        reset                 = 1'b1;
        arm                   = 1'b0;
        target_row            = '0;
        expected_pixel        = '0;
        expected_rgb_enable   = '1;
        expected_plane_enable = '1;
        serial_errors         = 0;
        tests_run             = 0;
        tests_failed          = 0;
        aborted               = 1'b0;
        $readmemh("verif/matrix_cases.txt", case_words);
        case_count = 0;
        while (case_count < MAX_CASES && !$isunknown(case_words[4 * case_count])) begin
            case_count++;
        end
        repeat (2) @(posedge clk_root);
        #DRIVE_DELAY;
        reset = 1'b0;
        if (case_count == 0) begin
            $display("No test cases found in verif/matrix_cases.txt");
            aborted = 1'b1;
        end

        for (int i = 0; i < case_count && !aborted; i++) begin
            errors_before = error_count + serial_errors;
            run_case(i, ok);
            tests_run++;
            aborted = !ok;
            if (!ok || error_count + serial_errors != errors_before) begin
                tests_failed++;
                $display("test %0d row %0d pixel %h: failed", i,
                         case_words[4 * i][4:0], case_words[4 * i + 1]);
            end else begin
                $display("test %0d row %0d pixel %h: passed", i,
                         case_words[4 * i][4:0], case_words[4 * i + 1]);
            end
        end

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count + serial_errors);
        if (aborted || tests_failed != 0 || error_count + serial_errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/matrix_pkg.sv
src/uart_rx.sv
src/control_module.sv
src/framebuffer_ram.sv
src/framebuffer_fetch.sv
src/matrix_scan.sv
src/pixel_split.sv
src/led_matrix_top.sv
verif/matrix_checker.sv
verif/led_matrix_sva.sv
verif/tb_led_matrix.sv

//--- verif/matrix_cases.txt
// row  rgb565  rgb_enable  brightness_enable, all in hex
// Rows 00..0F land on rgb1, rows 10..1F on rgb2
03 A5C3 7 3F
14 8410 7 3F
09 FFFF 2 3F
1F FFFF 5 3F
00 F81F 7 2D
10 6B5A 7 3E
